// ==== filelist.f ====
+incdir+include
logic/axi_bus_pkg.sv
logic/sram_mem_pkg.sv
logic/sram_bank.sv
logic/axi_sram_rd_ctrl.sv
logic/axi_sram_wr_ctrl.sv
logic/axi_sram_top.sv
verification/tb_clk_gen.sv
verification/axi_sram_tb.sv

// ==== include/axi_sram_cfg.svh ====
// Bus and memory sizing macros for the AXI SRAM slave, include wherever a width is needed
`ifndef AXI_SRAM_CFG_SVH
`define AXI_SRAM_CFG_SVH

// Bus widths
`define AXI_SRAM_DATA_W 64
`define AXI_SRAM_ADDR_W 32
`define AXI_SRAM_ID_W   4

// Memory bank size in 64-bit words
`define AXI_SRAM_DEPTH  1024

// log2 of the depth
`define AXI_SRAM_IDX_W  10

`endif

// ==== logic/axi_bus_pkg.sv ====
// AXI4 channel field types and controller state encodings, referenced by scoped names
`include "axi_sram_cfg.svh"

package axi_bus_pkg;

  typedef logic [`AXI_SRAM_ADDR_W-1:0] axi_addr_t;
  typedef logic [`AXI_SRAM_ID_W-1:0]   axi_id_t;
  typedef logic [7:0]                  axi_len_t;
  typedef logic [2:0]                  axi_size_t;
  typedef logic [1:0]                  axi_resp_t;

  // ------------------------------
  // Response codes
  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_SLVERR = 2'b10;

  // ------------------------------
  // Channel state machines
  typedef enum logic [0:0] {
    RD_IDLE,
    RD_BURST
  } rd_state_e;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_e;

endpackage

// ==== logic/axi_sram_rd_ctrl.sv ====
// AXI4 read channel controller, turns AR bursts into bank reads and R beats
`timescale 1ns/1ps

module axi_sram_rd_ctrl (
  input  logic                    i_aclk,
  input  logic                    i_rst_n,

  // Read address channel
  input  axi_bus_pkg::axi_id_t    i_arid,
  input  axi_bus_pkg::axi_addr_t  i_araddr,
  input  axi_bus_pkg::axi_len_t   i_arlen,
  input  axi_bus_pkg::axi_size_t  i_arsize,
  input  logic                    i_arvalid,
  output logic                    o_arready,

  // Read data channel
  output axi_bus_pkg::axi_id_t    o_rid,
  output axi_bus_pkg::axi_resp_t  o_rresp,
  output logic                    o_rlast,
  output logic                    o_rvalid,
  input  logic                    i_rready,

  // Bank read port
  output logic                    o_rd_en,
  output sram_mem_pkg::mem_idx_t  o_rd_idx,
  input  sram_mem_pkg::mem_word_t i_rd_data,
  output sram_mem_pkg::mem_word_t o_rdata
);

  localparam axi_bus_pkg::axi_size_t FULL_SIZE =
    axi_bus_pkg::axi_size_t'(sram_mem_pkg::OFFS_W);

  axi_bus_pkg::rd_state_e state_q;
  axi_bus_pkg::axi_id_t   id_q;
  axi_bus_pkg::axi_len_t  len_q;
  axi_bus_pkg::axi_len_t  beat_q;
  axi_bus_pkg::axi_addr_t addr_q;
  logic                   issue_done_q;
  logic                   rvalid_q;
  logic                   rerr_q;
  logic                   rlast_q;

  logic                   ar_fire;
  logic                   r_fire;
  logic                   issue;
  logic                   issue_last;
  logic                   issue_ok;
  axi_bus_pkg::axi_addr_t issue_addr;
  axi_bus_pkg::axi_len_t  issue_beat;

  assign ar_fire = i_arvalid && o_arready;
  assign r_fire  = o_rvalid && i_rready;

  // ------------------------------
  // Beat issue
  // Beat 0 goes out with the AR handshake, later beats when the R slot frees up
  always_comb begin
    if (state_q == axi_bus_pkg::RD_IDLE) begin
      issue      = ar_fire;
      issue_addr = i_araddr;
      issue_beat = '0;
      issue_last = (i_arlen == '0);
    end else begin
      issue      = !issue_done_q && (!rvalid_q || r_fire);
      issue_addr = addr_q;
      issue_beat = beat_q;
      issue_last = (beat_q == len_q);
    end
  end

  assign issue_ok = sram_mem_pkg::addr_in_range(issue_addr);
  assign o_rd_en  = issue && issue_ok;
  assign o_rd_idx = sram_mem_pkg::addr_to_idx(issue_addr);

  // ------------------------------
  // Control state
  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q      <= axi_bus_pkg::RD_IDLE;
      beat_q       <= '0;
      issue_done_q <= 1'b0;
      rvalid_q     <= 1'b0;
      rerr_q       <= 1'b0;
      rlast_q      <= 1'b0;
    end else begin
      case (state_q)
        axi_bus_pkg::RD_IDLE: begin
          if (ar_fire) begin
            state_q <= axi_bus_pkg::RD_BURST;
          end
        end
        axi_bus_pkg::RD_BURST: begin
          if (r_fire && rlast_q) begin
            state_q <= axi_bus_pkg::RD_IDLE;
          end
        end
        default: state_q <= axi_bus_pkg::RD_IDLE;
      endcase

      if (issue) begin
        beat_q       <= issue_beat + 8'd1;
        issue_done_q <= issue_last;
        rerr_q       <= !issue_ok;
        rlast_q      <= issue_last;
        rvalid_q     <= 1'b1;
      end else if (r_fire) begin
        rvalid_q     <= 1'b0;
      end
    end
  end

  // Burst payload
  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      id_q  <= i_arid;
      len_q <= i_arlen;
    end
    if (issue) begin
      addr_q <= issue_addr + axi_bus_pkg::axi_addr_t'(sram_mem_pkg::BEAT_BYTES);
    end
  end

  assign o_arready = (state_q == axi_bus_pkg::RD_IDLE);
  assign o_rvalid  = rvalid_q;
  assign o_rid     = id_q;
  assign o_rlast   = rlast_q;
  assign o_rresp   = rerr_q ? axi_bus_pkg::RESP_SLVERR : axi_bus_pkg::RESP_OKAY;
  // Out-of-range beats read as zero
  assign o_rdata   = rerr_q ? '0 : i_rd_data;

  // ------------------------------
  // Only full-width beats are supported
  a_arsize_full : assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    ar_fire |-> i_arsize == FULL_SIZE);

  // Stalled beat keeps its data across the bank read register
  a_rdata_hold : assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata));

endmodule

// ==== logic/axi_sram_top.sv ====
// AXI4 SRAM slave top, joins the read and write controllers to the shared bank
`timescale 1ns/1ps

module axi_sram_top (
  input  logic                    i_aclk,
  input  logic                    i_rst_n,

  // AW
  input  axi_bus_pkg::axi_id_t    i_awid,
  input  axi_bus_pkg::axi_addr_t  i_awaddr,
  input  axi_bus_pkg::axi_len_t   i_awlen,
  input  axi_bus_pkg::axi_size_t  i_awsize,
  input  logic                    i_awvalid,
  output logic                    o_awready,

  // W
  input  sram_mem_pkg::mem_word_t i_wdata,
  input  sram_mem_pkg::mem_strb_t i_wstrb,
  input  logic                    i_wlast,
  input  logic                    i_wvalid,
  output logic                    o_wready,

  // B
  output axi_bus_pkg::axi_id_t    o_bid,
  output axi_bus_pkg::axi_resp_t  o_bresp,
  output logic                    o_bvalid,
  input  logic                    i_bready,

  // AR
  input  axi_bus_pkg::axi_id_t    i_arid,
  input  axi_bus_pkg::axi_addr_t  i_araddr,
  input  axi_bus_pkg::axi_len_t   i_arlen,
  input  axi_bus_pkg::axi_size_t  i_arsize,
  input  logic                    i_arvalid,
  output logic                    o_arready,

  // R
  output axi_bus_pkg::axi_id_t    o_rid,
  output sram_mem_pkg::mem_word_t o_rdata,
  output axi_bus_pkg::axi_resp_t  o_rresp,
  output logic                    o_rlast,
  output logic                    o_rvalid,
  input  logic                    i_rready
);

  logic                    wr_en;
  sram_mem_pkg::mem_idx_t  wr_idx;
  sram_mem_pkg::mem_word_t wr_data;
  sram_mem_pkg::mem_strb_t wr_strb;
  logic                    rd_en;
  sram_mem_pkg::mem_idx_t  rd_idx;
  sram_mem_pkg::mem_word_t rd_data;

  axi_sram_wr_ctrl wr_ctrl_i (
    .i_aclk    (i_aclk),    .i_rst_n   (i_rst_n),
    .i_awid    (i_awid),    .i_awaddr  (i_awaddr),  .i_awlen   (i_awlen),
    .i_awsize  (i_awsize),  .i_awvalid (i_awvalid), .o_awready (o_awready),
    .i_wdata   (i_wdata),   .i_wstrb   (i_wstrb),   .i_wlast   (i_wlast),
    .i_wvalid  (i_wvalid),  .o_wready  (o_wready),
    .o_bid     (o_bid),     .o_bresp   (o_bresp),   .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .o_wr_en   (wr_en),     .o_wr_idx  (wr_idx),    .o_wr_data (wr_data),
    .o_wr_strb (wr_strb)
  );

  axi_sram_rd_ctrl rd_ctrl_i (
    .i_aclk    (i_aclk),    .i_rst_n   (i_rst_n),
    .i_arid    (i_arid),    .i_araddr  (i_araddr),  .i_arlen   (i_arlen),
    .i_arsize  (i_arsize),  .i_arvalid (i_arvalid), .o_arready (o_arready),
    .o_rid     (o_rid),     .o_rresp   (o_rresp),   .o_rlast   (o_rlast),
    .o_rvalid  (o_rvalid),  .i_rready  (i_rready),
    .o_rd_en   (rd_en),     .o_rd_idx  (rd_idx),    .i_rd_data (rd_data),
    .o_rdata   (o_rdata)
  );

  sram_bank bank_i (
    .i_aclk    (i_aclk),    .i_rst_n   (i_rst_n),
    .i_wr_en   (wr_en),     .i_wr_idx  (wr_idx),
    .i_wr_data (wr_data),   .i_wr_strb (wr_strb),
    .i_rd_en   (rd_en),     .i_rd_idx  (rd_idx),
    .o_rd_data (rd_data)
  );

endmodule

// ==== logic/axi_sram_wr_ctrl.sv ====
// AXI4 write channel controller, writes W beats into the bank and returns one B per burst
`timescale 1ns/1ps

module axi_sram_wr_ctrl (
  input  logic                    i_aclk,
  input  logic                    i_rst_n,

  // Write address channel
  input  axi_bus_pkg::axi_id_t    i_awid,
  input  axi_bus_pkg::axi_addr_t  i_awaddr,
  input  axi_bus_pkg::axi_len_t   i_awlen,
  input  axi_bus_pkg::axi_size_t  i_awsize,
  input  logic                    i_awvalid,
  output logic                    o_awready,

  // Write data channel
  input  sram_mem_pkg::mem_word_t i_wdata,
  input  sram_mem_pkg::mem_strb_t i_wstrb,
  input  logic                    i_wlast,
  input  logic                    i_wvalid,
  output logic                    o_wready,

  // Write response channel
  output axi_bus_pkg::axi_id_t    o_bid,
  output axi_bus_pkg::axi_resp_t  o_bresp,
  output logic                    o_bvalid,
  input  logic                    i_bready,

  // Bank write port
  output logic                    o_wr_en,
  output sram_mem_pkg::mem_idx_t  o_wr_idx,
  output sram_mem_pkg::mem_word_t o_wr_data,
  output sram_mem_pkg::mem_strb_t o_wr_strb
);

  localparam axi_bus_pkg::axi_size_t FULL_SIZE =
    axi_bus_pkg::axi_size_t'(sram_mem_pkg::OFFS_W);

  axi_bus_pkg::wr_state_e state_q;
  axi_bus_pkg::axi_id_t   id_q;
  axi_bus_pkg::axi_len_t  len_q;
  axi_bus_pkg::axi_len_t  beat_q;
  axi_bus_pkg::axi_addr_t addr_q;
  logic                   err_q;
  logic                   bvalid_q;

  logic                   aw_fire;
  logic                   w_fire;
  logic                   b_fire;
  logic                   beat_ok;

  assign aw_fire = i_awvalid && o_awready;
  assign w_fire  = i_wvalid && o_wready;
  assign b_fire  = o_bvalid && i_bready;

  assign beat_ok = sram_mem_pkg::addr_in_range(addr_q);

  // ------------------------------
  // Bank write, committed on the W handshake edge
  assign o_wr_en   = w_fire && beat_ok;
  assign o_wr_idx  = sram_mem_pkg::addr_to_idx(addr_q);
  assign o_wr_data = i_wdata;
  assign o_wr_strb = i_wstrb;

  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q  <= axi_bus_pkg::WR_IDLE;
      beat_q   <= '0;
      err_q    <= 1'b0;
      bvalid_q <= 1'b0;
    end else begin
      case (state_q)
        axi_bus_pkg::WR_IDLE: begin
          if (aw_fire) begin
            state_q <= axi_bus_pkg::WR_DATA;
            beat_q  <= '0;
            err_q   <= 1'b0;
          end
        end
        axi_bus_pkg::WR_DATA: begin
          if (w_fire) begin
            beat_q <= beat_q + 8'd1;
            // Sticky over the whole burst
            err_q  <= err_q || !beat_ok;
            if (i_wlast) begin
              state_q  <= axi_bus_pkg::WR_RESP;
              bvalid_q <= 1'b1;
            end
          end
        end
        axi_bus_pkg::WR_RESP: begin
          if (b_fire) begin
            state_q  <= axi_bus_pkg::WR_IDLE;
            bvalid_q <= 1'b0;
          end
        end
        default: state_q <= axi_bus_pkg::WR_IDLE;
      endcase
    end
  end

  // Burst payload, address steps one word per beat
  always_ff @(posedge i_aclk) begin
    if (aw_fire) begin
      id_q   <= i_awid;
      len_q  <= i_awlen;
      addr_q <= i_awaddr;
    end else if (w_fire) begin
      addr_q <= addr_q + axi_bus_pkg::axi_addr_t'(sram_mem_pkg::BEAT_BYTES);
    end
  end

  assign o_awready = (state_q == axi_bus_pkg::WR_IDLE);
  assign o_wready  = (state_q == axi_bus_pkg::WR_DATA);
  assign o_bvalid  = bvalid_q;
  assign o_bid     = id_q;
  assign o_bresp   = err_q ? axi_bus_pkg::RESP_SLVERR : axi_bus_pkg::RESP_OKAY;

  // ------------------------------
  // Master must close the burst on beat AWLEN
  a_wlast_beat : assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    w_fire |-> (i_wlast == (beat_q == len_q)));

  a_awsize_full : assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    aw_fire |-> i_awsize == FULL_SIZE);

endmodule

// ==== logic/sram_bank.sv ====
// Byte-enabled synchronous SRAM bank, one write port and one registered read port
`timescale 1ns/1ps
`include "axi_sram_cfg.svh"

module sram_bank (
  input  logic                  i_aclk,
  input  logic                  i_rst_n,

  // Write port
  input  logic                  i_wr_en,
  input  sram_mem_pkg::mem_idx_t  i_wr_idx,
  input  sram_mem_pkg::mem_word_t i_wr_data,
  input  sram_mem_pkg::mem_strb_t i_wr_strb,

  // Read port
  input  logic                  i_rd_en,
  input  sram_mem_pkg::mem_idx_t  i_rd_idx,
  output sram_mem_pkg::mem_word_t o_rd_data
);

  sram_mem_pkg::mem_word_t mem [0:`AXI_SRAM_DEPTH-1];

  // ------------------------------
  // Write port, only strobed bytes change
  always_ff @(posedge i_aclk) begin
    if (i_wr_en) begin
      for (int b = 0; b < $bits(sram_mem_pkg::mem_strb_t); b++) begin
        if (i_wr_strb[b]) begin
          mem[i_wr_idx][8*b +: 8] <= i_wr_data[8*b +: 8];
        end
      end
    end
  end

  // ------------------------------
  // Read register
  // Same-cycle collision sees the old word
  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_rd_data <= '0;
    end else if (i_rd_en) begin
      o_rd_data <= mem[i_rd_idx];
    end
  end

endmodule

// ==== logic/sram_mem_pkg.sv ====
// Memory-side word, strobe and index types plus address helpers for the SRAM bank
`include "axi_sram_cfg.svh"

package sram_mem_pkg;

  typedef logic [`AXI_SRAM_DATA_W-1:0]   mem_word_t;
  typedef logic [`AXI_SRAM_DATA_W/8-1:0] mem_strb_t;
  typedef logic [`AXI_SRAM_IDX_W-1:0]    mem_idx_t;

  // Byte offset bits within one word
  localparam int unsigned OFFS_W     = $clog2(`AXI_SRAM_DATA_W / 8);
  localparam int unsigned BEAT_BYTES = `AXI_SRAM_DATA_W / 8;

  function automatic mem_idx_t addr_to_idx(input logic [`AXI_SRAM_ADDR_W-1:0] addr);
    return addr[OFFS_W +: `AXI_SRAM_IDX_W];
  endfunction

  // All bits above the word index must be zero
  function automatic logic addr_in_range(input logic [`AXI_SRAM_ADDR_W-1:0] addr);
    return addr[`AXI_SRAM_ADDR_W-1:`AXI_SRAM_IDX_W+OFFS_W] == '0;
  endfunction

endpackage

// ==== verification/axi_sram_tb.sv ====
// Self-checking testbench for the AXI SRAM slave, run with the project file list
`timescale 1ns/1ps
`include "axi_sram_cfg.svh"

module axi_sram_tb;

  localparam logic [31:0] SEED       = 32'd55589;
  // About 1500 cycles of bursts with stalls, the rest is margin
  localparam int          MAX_CYCLES = 6000;
  localparam int          DEPTH      = `AXI_SRAM_DEPTH;
  localparam logic [1:0]  OKAY       = 2'b00;
  localparam logic [1:0]  SLVERR     = 2'b10;

  logic                    i_aclk;
  logic                    i_rst_n;
  axi_bus_pkg::axi_id_t    i_awid;
  axi_bus_pkg::axi_addr_t  i_awaddr;
  axi_bus_pkg::axi_len_t   i_awlen;
  axi_bus_pkg::axi_size_t  i_awsize;
  logic                    i_awvalid;
  logic                    o_awready;
  sram_mem_pkg::mem_word_t i_wdata;
  sram_mem_pkg::mem_strb_t i_wstrb;
  logic                    i_wlast;
  logic                    i_wvalid;
  logic                    o_wready;
  axi_bus_pkg::axi_id_t    o_bid;
  axi_bus_pkg::axi_resp_t  o_bresp;
  logic                    o_bvalid;
  logic                    i_bready;
  axi_bus_pkg::axi_id_t    i_arid;
  axi_bus_pkg::axi_addr_t  i_araddr;
  axi_bus_pkg::axi_len_t   i_arlen;
  axi_bus_pkg::axi_size_t  i_arsize;
  logic                    i_arvalid;
  logic                    o_arready;
  axi_bus_pkg::axi_id_t    o_rid;
  sram_mem_pkg::mem_word_t o_rdata;
  axi_bus_pkg::axi_resp_t  o_rresp;
  logic                    o_rlast;
  logic                    o_rvalid;
  logic                    i_rready;

  logic [63:0] shadow [0:DEPTH-1];
  logic [63:0] r_data_q[$];
  logic [1:0]  r_resp_q[$];
  logic        r_last_q[$];
  logic [3:0]  r_id_q[$];
  logic [1:0]  b_resp_q[$];
  logic [3:0]  b_id_q[$];

  // Expected head of each queue, loaded at the falling edge before a transfer
  logic        r_have = 1'b0;
  logic [63:0] r_exp_data;
  logic [1:0]  r_exp_resp;
  logic        r_exp_last;
  logic [3:0]  r_exp_id;
  logic        b_have = 1'b0;
  logic [1:0]  b_exp_resp;
  logic [3:0]  b_exp_id;

  logic [31:0] rng;
  logic [31:0] stall_rng;
  logic        stall_en = 1'b0;
  int          cycle_cnt = 0;
  string       test_name = "reset";
  logic        r_fire;
  logic        b_fire;

  assign r_fire = o_rvalid && i_rready;
  assign b_fire = o_bvalid && i_bready;

  tb_clk_gen clk_gen_i (.o_aclk(i_aclk), .o_rst_n(i_rst_n));

  axi_sram_top dut_i (.*);

  // ------------------------------
  // Failure reporting
  task automatic halt_failed();
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic value_mismatch(input string field, input logic [63:0] exp_v,
                                input logic [63:0] act_v);
    $display("[FAIL] %s %s: expected %h, actual %h", test_name, field, exp_v, act_v);
    halt_failed();
  endtask

  task automatic end_with_failure(input string why);
    $display("ERROR in %s: %s", test_name, why);
    halt_failed();
  endtask

  // ------------------------------
  // Random numbers
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = lcg_next(rng);
    return rng;
  endfunction

  // Upper bits only, the low LCG bits repeat quickly
  function automatic int rand_below(input int n);
    return int'((next_rand() >> 8) % n);
  endfunction

  // Word index is the byte address over 8, valid below the bank depth
  function automatic bit in_range(input logic [31:0] addr);
    return (addr >> 3) < DEPTH;
  endfunction

  // ------------------------------
  // Master tasks, entered and left 1 ns after a rising edge
  task automatic write_burst(input logic [3:0] id, input logic [31:0] addr, input int len,
                             input bit rand_strb);
    logic [31:0] a;
    logic [31:0] hi;
    logic [31:0] lo;
    logic [7:0]  s;
    logic        err;
    err = 1'b0;
    for (int i = 0; i <= len; i++) begin
      if (!in_range(addr + 32'(8 * i))) err = 1'b1;
    end
    b_id_q.push_back(id);
    b_resp_q.push_back(err ? SLVERR : OKAY);
    i_awid    = id;
    i_awaddr  = addr;
    i_awlen   = 8'(len);
    i_awsize  = 3'd3;
    i_awvalid = 1'b1;
    do @(posedge i_aclk); while (!o_awready);
    #1 i_awvalid = 1'b0;
    for (int i = 0; i <= len; i++) begin
      a  = addr + 32'(8 * i);
      hi = next_rand();
      lo = next_rand();
      s  = rand_strb ? 8'(next_rand() >> 20) : 8'hff;
      i_wdata  = {hi, lo};
      i_wstrb  = s;
      i_wlast  = (i == len);
      i_wvalid = 1'b1;
      do @(posedge i_aclk); while (!o_wready);
      if (in_range(a)) begin
        for (int b = 0; b < 8; b++) begin
          if (s[b]) shadow[a >> 3][8*b +: 8] = i_wdata[8*b +: 8];
        end
      end
      #1;
    end
    i_wvalid = 1'b0;
    i_wlast  = 1'b0;
    do @(posedge i_aclk); while (!b_fire);
    #1;
  endtask

  task automatic read_burst(input logic [3:0] id, input logic [31:0] addr, input int len);
    logic [31:0] a;
    for (int i = 0; i <= len; i++) begin
      a = addr + 32'(8 * i);
      r_data_q.push_back(in_range(a) ? shadow[a >> 3] : 64'd0);
      r_resp_q.push_back(in_range(a) ? OKAY : SLVERR);
      r_last_q.push_back(i == len);
      r_id_q.push_back(id);
    end
    i_arid    = id;
    i_araddr  = addr;
    i_arlen   = 8'(len);
    i_arsize  = 3'd3;
    i_arvalid = 1'b1;
    do @(posedge i_aclk); while (!o_arready);
    #1 i_arvalid = 1'b0;
    do @(posedge i_aclk); while (!(r_fire && o_rlast));
    #1;
  endtask

  // Fill with full strobes first so no byte of the bank stays unknown
  task automatic random_bursts(input int count);
    int          len;
    logic [31:0] base;
    logic [3:0]  id;
    for (int n = 0; n < count; n++) begin
      len  = rand_below(16);
      base = 32'(rand_below(DEPTH - 16) * 8);
      id   = 4'(rand_below(16));
      write_burst(id, base, len, 1'b0);
      write_burst(id + 4'd1, base, len, 1'b1);
      read_burst(id + 4'd2, base, len);
    end
  endtask

  // ------------------------------
  // Response monitor and cycle limit
  always @(negedge i_aclk) begin
    r_have = 1'b0;
    b_have = 1'b0;
    if (i_rst_n && r_fire && r_data_q.size() > 0) begin
      r_have     = 1'b1;
      r_exp_data = r_data_q.pop_front();
      r_exp_resp = r_resp_q.pop_front();
      r_exp_last = r_last_q.pop_front();
      r_exp_id   = r_id_q.pop_front();
    end
    if (i_rst_n && b_fire && b_resp_q.size() > 0) begin
      b_have     = 1'b1;
      b_exp_resp = b_resp_q.pop_front();
      b_exp_id   = b_id_q.pop_front();
    end
  end

  always @(posedge i_aclk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      end_with_failure("timeout, the cycle limit was reached before all tests finished");
    end
  end

  // Stall pattern for RREADY and BREADY
  always @(posedge i_aclk) begin
    stall_rng = lcg_next(stall_rng);
    #1;
    i_rready = !stall_en || (stall_rng[30:29] != 2'b00);
    i_bready = !stall_en || (stall_rng[27:26] != 2'b00);
  end

  // ------------------------------
  // Checks
  a_reset_state : assert property (@(posedge i_aclk)
    $rose(i_rst_n) |-> o_arready && o_awready && !o_rvalid && !o_wready && !o_bvalid)
    else end_with_failure("channel outputs are not at their reset values");

  a_r_expected : assert property (@(posedge i_aclk) disable iff (!i_rst_n) r_fire |-> r_have)
    else end_with_failure("an R beat arrived with no read beat outstanding");
  a_r_data : assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    r_fire && r_have |-> o_rdata == r_exp_data)
    else value_mismatch("RDATA", r_exp_data, $sampled(o_rdata));
  a_r_resp : assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    r_fire && r_have |-> o_rresp == r_exp_resp)
    else value_mismatch("RRESP", 64'(r_exp_resp), 64'($sampled(o_rresp)));
  a_r_last : assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    r_fire && r_have |-> o_rlast == r_exp_last)
    else value_mismatch("RLAST", 64'(r_exp_last), 64'($sampled(o_rlast)));
  a_r_id : assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    r_fire && r_have |-> o_rid == r_exp_id)
    else value_mismatch("RID", 64'(r_exp_id), 64'($sampled(o_rid)));
  a_r_hold : assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata) && $stable(o_rid)
      && $stable(o_rresp) && $stable(o_rlast))
    else end_with_failure("the R channel changed while it was stalled");

  a_b_expected : assert property (@(posedge i_aclk) disable iff (!i_rst_n) b_fire |-> b_have)
    else end_with_failure("a B response arrived with no write outstanding");
  a_b_resp : assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    b_fire && b_have |-> o_bresp == b_exp_resp)
    else value_mismatch("BRESP", 64'(b_exp_resp), 64'($sampled(o_bresp)));
  a_b_id : assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    b_fire && b_have |-> o_bid == b_exp_id)
    else value_mismatch("BID", 64'(b_exp_id), 64'($sampled(o_bid)));
  a_b_hold : assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_bvalid && !i_bready |=> o_bvalid && $stable(o_bid) && $stable(o_bresp))
    else end_with_failure("the B channel changed while it was stalled");

  // ------------------------------
  // Stimulus
  initial begin
    rng       = SEED;
    stall_rng = lcg_next(SEED);
    i_awid    = '0;
    i_awaddr  = '0;
    i_awlen   = '0;
    i_awsize  = 3'd3;
    i_awvalid = 1'b0;
    i_wdata   = '0;
    i_wstrb   = '0;
    i_wlast   = 1'b0;
    i_wvalid  = 1'b0;
    i_bready  = 1'b1;
    i_arid    = '0;
    i_araddr  = '0;
    i_arlen   = '0;
    i_arsize  = 3'd3;
    i_arvalid = 1'b0;
    i_rready  = 1'b1;
    @(posedge i_rst_n);
    @(posedge i_aclk);
    #1;
    test_name = "single_beat";
    write_burst(4'd5, 32'h100, 0, 1'b0);
    read_burst(4'd9, 32'h100, 0);
    test_name = "random_bursts";
    random_bursts(8);
    test_name = "stalled_bursts";
    stall_en = 1'b1;
    random_bursts(8);
    // Words 0..3 alias the beats past the end if the range gate fails
    test_name = "memory_end";
    write_burst(4'd1, 32'h0, 3, 1'b0);
    write_burst(4'd2, 32'((DEPTH - 4) * 8), 7, 1'b0);
    read_burst(4'd3, 32'((DEPTH - 4) * 8), 7);
    read_burst(4'd4, 32'h0, 3);
    test_name = "concurrent";
    write_burst(4'd6, 32'(300 * 8), 15, 1'b0);
    fork
      read_burst(4'd7, 32'(300 * 8), 15);
      write_burst(4'd8, 32'(700 * 8), 11, 1'b0);
    join
    read_burst(4'd10, 32'(700 * 8), 11);
    test_name = "end_of_run";
    if (r_data_q.size() != 0 || b_resp_q.size() != 0) begin
      end_with_failure("responses were still expected at the end of the run");
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

// ==== verification/tb_clk_gen.sv ====
// Testbench clock and reset source, instantiated once by the AXI SRAM testbench
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS  = 20,
  parameter int unsigned RST_CYCLES = 2
) (
  output logic o_aclk,
  output logic o_rst_n
);

  initial begin
    o_aclk = 1'b0;
    forever #(PERIOD_NS / 2) o_aclk = ~o_aclk;
  end

  // Release just after an edge so the first active cycle is clean
  initial begin
    o_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_aclk);
    #1 o_rst_n = 1'b1;
  end

endmodule
